//--- compile.f
+incdir+hdl
+incdir+test
hdl/mmu_pkg.sv
hdl/sv32_tlb.sv
hdl/fetch_xlate.sv
hdl/lsu_xlate.sv
hdl/mmu_sv32.sv
test/mmu_tb.sv

//--- hdl/fetch_xlate.sv
// ------------------------------
// fetch path translation, same cycle as the request
// ------------------------------
`timescale 1ns/1ps
`include "mmu_defs.svh"

module fetch_xlate (
  input  logic                   enable_translation_i,
  input  mmu_pkg::priv_lvl_e     priv_lvl_i,
  input  logic                   fetch_req_i,
  input  logic [`MMU_VLEN-1:0]   fetch_vaddr_i,
  // itlb result for fetch_vaddr_i
  input  logic                   itlb_hit_i,
  input  mmu_pkg::pte_t          itlb_content_i,
  input  logic                   itlb_is_4m_i,
  output logic                   fetch_valid_o,
  output logic [`MMU_PLEN-1:0]   fetch_paddr_o,
  output mmu_pkg::exception_t    fetch_exception_o,
  output logic                   itlb_miss_o
);

  logic iaccess_err;

  // u pages are off limits to s-mode fetch, and the reverse
  assign iaccess_err = (priv_lvl_i == mmu_pkg::PRIV_U && !itlb_content_i.u)
                    || (priv_lvl_i == mmu_pkg::PRIV_S && itlb_content_i.u);

  always_comb begin : xlate
    // bare mode, zero-extend to 34 bits
    fetch_valid_o = fetch_req_i;
    fetch_paddr_o = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, fetch_vaddr_i};
    fetch_exception_o.cause = mmu_pkg::EXC_NONE;
    fetch_exception_o.tval  = '0;
    fetch_exception_o.valid = 1'b0;
    if (enable_translation_i) begin
      fetch_valid_o = itlb_hit_i;
      fetch_paddr_o = {itlb_content_i.ppn, fetch_vaddr_i[11:0]};
      // megapage keeps vpn0 from the virtual address
      if (itlb_is_4m_i) begin
        fetch_paddr_o[21:12] = fetch_vaddr_i[21:12];
      end
      if (itlb_hit_i && iaccess_err) begin
        fetch_exception_o.cause = mmu_pkg::EXC_INSTR_PAGE_FAULT;
        fetch_exception_o.tval  = fetch_vaddr_i;
        fetch_exception_o.valid = 1'b1;
      end
    end
  end

  // requester retries after the refill
  assign itlb_miss_o = enable_translation_i && fetch_req_i && !itlb_hit_i;

  // a fault is only meaningful on a delivered fetch of a live request
  always_comb begin : chk_exc
    a_exc_with_valid : assert (!fetch_exception_o.valid || (fetch_valid_o && fetch_req_i))
      else $error("fetch exception without a valid fetch request");
  end

endmodule

//--- hdl/lsu_xlate.sv
// ------------------------------
// load/store translation, result one cycle after the request
// ------------------------------
`timescale 1ns/1ps
`include "mmu_defs.svh"

module lsu_xlate (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_ld_st_translation_i,
  input  mmu_pkg::priv_lvl_e     ld_st_priv_lvl_i,
  input  logic                   sum_i,
  // request
  input  logic                   lsu_req_i,
  input  logic [`MMU_VLEN-1:0]   lsu_vaddr_i,
  input  logic                   lsu_is_store_i,
  // dtlb result for lsu_vaddr_i
  input  logic                   dtlb_hit_i,
  input  mmu_pkg::pte_t          dtlb_content_i,
  input  logic                   dtlb_is_4m_i,
  // request cycle
  output logic                   lsu_dtlb_hit_o,
  output logic [`MMU_PPNW-1:0]   lsu_dtlb_ppn_o,
  // result cycle
  output logic                   lsu_valid_o,
  output logic [`MMU_PLEN-1:0]   lsu_paddr_o,
  output mmu_pkg::exception_t    lsu_exception_o,
  output logic                   dtlb_miss_o
);

  logic                 req_q;
  logic                 hit_q;
  logic [`MMU_VLEN-1:0] vaddr_q;
  logic                 is_store_q;
  logic                 is_4m_q;
  mmu_pkg::pte_t        pte_q;
  logic                 daccess_err;

  // ------------------------------
  // request cycle
  // ------------------------------
  // always ready when not translating
  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb_hit_i : 1'b1;
  assign lsu_dtlb_ppn_o = en_ld_st_translation_i ? dtlb_content_i.ppn
                                                 : {2'b00, lsu_vaddr_i[31:12]};
  assign dtlb_miss_o    = en_ld_st_translation_i && lsu_req_i && !dtlb_hit_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      req_q <= lsu_req_i;
      hit_q <= dtlb_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q    <= lsu_vaddr_i;
    is_store_q <= lsu_is_store_i;
    is_4m_q    <= dtlb_is_4m_i;
    pte_q      <= dtlb_content_i;
  end

  // ------------------------------
  // result cycle
  // ------------------------------
  // s-mode needs sum to touch u pages, u-mode needs the u flag
  assign daccess_err = (ld_st_priv_lvl_i == mmu_pkg::PRIV_S && !sum_i && pte_q.u)
                    || (ld_st_priv_lvl_i == mmu_pkg::PRIV_U && !pte_q.u);

  always_comb begin : result
    lsu_valid_o = req_q;
    lsu_paddr_o = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, vaddr_q};
    lsu_exception_o.cause = mmu_pkg::EXC_NONE;
    lsu_exception_o.tval  = '0;
    lsu_exception_o.valid = 1'b0;
    if (en_ld_st_translation_i) begin
      lsu_valid_o = req_q && hit_q;
      lsu_paddr_o = {pte_q.ppn, vaddr_q[11:0]};
      if (is_4m_q) begin
        lsu_paddr_o[21:12] = vaddr_q[21:12];
      end
      if (req_q && hit_q) begin
        // stores also need w and a set dirty bit
        if (is_store_q && (!pte_q.w || !pte_q.d || daccess_err)) begin
          lsu_exception_o.cause = mmu_pkg::EXC_STORE_PAGE_FAULT;
          lsu_exception_o.tval  = vaddr_q;
          lsu_exception_o.valid = 1'b1;
        end else if (!is_store_q && daccess_err) begin
          lsu_exception_o.cause = mmu_pkg::EXC_LOAD_PAGE_FAULT;
          lsu_exception_o.tval  = vaddr_q;
          lsu_exception_o.valid = 1'b1;
        end
      end
    end
  end

  // result cycle reads the live mode, so it must hold while a request is pending
  a_mode_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_q |-> $stable(en_ld_st_translation_i));

endmodule

//--- hdl/mmu_defs.svh
// ------------------------------
// widths and sizes shared by the sv32 mmu
// ------------------------------
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// virtual address width, sv32
`define MMU_VLEN 32

// physical address width, 34 bits in sv32
`define MMU_PLEN 34

// physical page number width
`define MMU_PPNW 22

// address space identifier width
`define MMU_ASID_W 4

// tlb sizes
// fetch side stays tiny, data side gets a little more reach
`define MMU_ITLB_ENTRIES 2
`define MMU_DTLB_ENTRIES 4

`endif

//--- hdl/mmu_pkg.sv
// ------------------------------
// mmu types: privilege, sv32 pte, exception cause and record
// ------------------------------
`include "mmu_defs.svh"

package mmu_pkg;

  // privilege levels, hypervisor encoding unused
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // sv32 leaf pte, msb first
  typedef struct packed {
    logic [`MMU_PPNW-1:0] ppn;
    // reserved for software
    logic [1:0]           rsw;
    logic                 d;
    logic                 a;
    logic                 g;
    logic                 u;
    logic                 x;
    logic                 w;
    logic                 r;
    logic                 v;
  } pte_t;

  // only the page faults this unit can raise
  typedef enum logic [3:0] {
    EXC_NONE             = 4'd0,
    EXC_INSTR_PAGE_FAULT = 4'd12,
    EXC_LOAD_PAGE_FAULT  = 4'd13,
    EXC_STORE_PAGE_FAULT = 4'd15
  } exc_cause_e;

  // tval carries the faulting virtual address
  typedef struct packed {
    exc_cause_e           cause;
    logic [`MMU_VLEN-1:0] tval;
    logic                 valid;
  } exception_t;

endpackage

//--- hdl/mmu_sv32.sv
// ------------------------------
// sv32 mmu top: itlb, dtlb, fetch and load/store translation
// ------------------------------
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_sv32 (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // csr state
  input  logic                   enable_translation_i,
  input  logic                   en_ld_st_translation_i,
  input  mmu_pkg::priv_lvl_e     priv_lvl_i,
  input  mmu_pkg::priv_lvl_e     ld_st_priv_lvl_i,
  input  logic                   sum_i,
  input  logic [`MMU_ASID_W-1:0] asid_i,
  // selective flush, both tlbs
  input  logic                   flush_tlb_i,
  input  logic [`MMU_ASID_W-1:0] flush_asid_i,
  input  logic [`MMU_VLEN-1:0]   flush_vaddr_i,
  // external refill strobe
  input  logic                   refill_i,
  input  logic                   refill_itlb_i,
  input  logic [`MMU_VLEN-1:0]   refill_vaddr_i,
  input  logic [`MMU_ASID_W-1:0] refill_asid_i,
  input  mmu_pkg::pte_t          refill_pte_i,
  input  logic                   refill_is_4m_i,
  // fetch
  input  logic                   fetch_req_i,
  input  logic [`MMU_VLEN-1:0]   fetch_vaddr_i,
  output logic                   fetch_valid_o,
  output logic [`MMU_PLEN-1:0]   fetch_paddr_o,
  output mmu_pkg::exception_t    fetch_exception_o,
  output logic                   itlb_miss_o,
  // load/store
  input  logic                   lsu_req_i,
  input  logic [`MMU_VLEN-1:0]   lsu_vaddr_i,
  input  logic                   lsu_is_store_i,
  output logic                   lsu_dtlb_hit_o,
  output logic [`MMU_PPNW-1:0]   lsu_dtlb_ppn_o,
  output logic                   lsu_valid_o,
  output logic [`MMU_PLEN-1:0]   lsu_paddr_o,
  output mmu_pkg::exception_t    lsu_exception_o,
  output logic                   dtlb_miss_o
);

  logic          itlb_update, dtlb_update;
  logic          itlb_hit, dtlb_hit;
  logic          itlb_is_4m, dtlb_is_4m;
  mmu_pkg::pte_t itlb_content, dtlb_content;

  // refill goes to one tlb only
  assign itlb_update = refill_i && refill_itlb_i;
  assign dtlb_update = refill_i && !refill_itlb_i;

  sv32_tlb #(.ENTRIES(`MMU_ITLB_ENTRIES)) i_itlb (
    .clk_i, .rst_ni,
    .flush_i        (flush_tlb_i),
    .flush_asid_i, .flush_vaddr_i,
    .update_i       (itlb_update),
    .update_vaddr_i (refill_vaddr_i),
    .update_asid_i  (refill_asid_i),
    .update_pte_i   (refill_pte_i),
    .update_is_4m_i (refill_is_4m_i),
    .lu_access_i    (fetch_req_i),
    .lu_asid_i      (asid_i),
    .lu_vaddr_i     (fetch_vaddr_i),
    .lu_hit_o       (itlb_hit),
    .lu_content_o   (itlb_content),
    .lu_is_4m_o     (itlb_is_4m)
  );

  sv32_tlb #(.ENTRIES(`MMU_DTLB_ENTRIES)) i_dtlb (
    .clk_i, .rst_ni,
    .flush_i        (flush_tlb_i),
    .flush_asid_i, .flush_vaddr_i,
    .update_i       (dtlb_update),
    .update_vaddr_i (refill_vaddr_i),
    .update_asid_i  (refill_asid_i),
    .update_pte_i   (refill_pte_i),
    .update_is_4m_i (refill_is_4m_i),
    .lu_access_i    (lsu_req_i),
    .lu_asid_i      (asid_i),
    .lu_vaddr_i     (lsu_vaddr_i),
    .lu_hit_o       (dtlb_hit),
    .lu_content_o   (dtlb_content),
    .lu_is_4m_o     (dtlb_is_4m)
  );

  fetch_xlate i_fetch (
    .enable_translation_i, .priv_lvl_i, .fetch_req_i, .fetch_vaddr_i,
    .itlb_hit_i     (itlb_hit),
    .itlb_content_i (itlb_content),
    .itlb_is_4m_i   (itlb_is_4m),
    .fetch_valid_o, .fetch_paddr_o, .fetch_exception_o, .itlb_miss_o
  );

  lsu_xlate i_lsu (
    .clk_i, .rst_ni, .en_ld_st_translation_i, .ld_st_priv_lvl_i, .sum_i,
    .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i,
    .dtlb_hit_i     (dtlb_hit),
    .dtlb_content_i (dtlb_content),
    .dtlb_is_4m_i   (dtlb_is_4m),
    .lsu_dtlb_hit_o, .lsu_dtlb_ppn_o, .lsu_valid_o, .lsu_paddr_o,
    .lsu_exception_o, .dtlb_miss_o
  );

endmodule

//--- hdl/sv32_tlb.sv
// ------------------------------
// fully associative sv32 tlb
// lookup, refill with round-robin replacement, selective flush
// ------------------------------
`timescale 1ns/1ps
`include "mmu_defs.svh"

module sv32_tlb #(
  parameter int unsigned ENTRIES = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // sfence.vma style flush
  input  logic                   flush_i,
  input  logic [`MMU_ASID_W-1:0] flush_asid_i,
  input  logic [`MMU_VLEN-1:0]   flush_vaddr_i,
  // refill
  input  logic                   update_i,
  input  logic [`MMU_VLEN-1:0]   update_vaddr_i,
  input  logic [`MMU_ASID_W-1:0] update_asid_i,
  input  mmu_pkg::pte_t          update_pte_i,
  input  logic                   update_is_4m_i,
  // lookup
  input  logic                   lu_access_i,
  input  logic [`MMU_ASID_W-1:0] lu_asid_i,
  input  logic [`MMU_VLEN-1:0]   lu_vaddr_i,
  output logic                   lu_hit_o,
  output mmu_pkg::pte_t          lu_content_o,
  output logic                   lu_is_4m_o
);

  localparam int unsigned IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  // tag and payload arrays
  logic [9:0]             vpn1_q    [ENTRIES];
  logic [9:0]             vpn0_q    [ENTRIES];
  logic [`MMU_ASID_W-1:0] asid_q    [ENTRIES];
  logic                   is_4m_q   [ENTRIES];
  logic                   glob_q    [ENTRIES];
  mmu_pkg::pte_t          content_q [ENTRIES];

  logic [ENTRIES-1:0] valid_q, valid_d;
  logic [ENTRIES-1:0] hit_vec;
  logic [ENTRIES-1:0] flush_vec;
  logic [IDX_W-1:0]   rr_q, rr_next;
  logic [IDX_W-1:0]   repl_idx;
  logic               all_valid;

  // ------------------------------
  // lookup
  // ------------------------------
  always_comb begin : lookup
    lu_content_o = '0;
    lu_is_4m_o   = 1'b0;
    for (int i = 0; i < ENTRIES; i++) begin
      // asid ignored for global pages, vpn0 ignored for megapages
      hit_vec[i] = lu_access_i && valid_q[i]
                   && (asid_q[i] == lu_asid_i || glob_q[i])
                   && vpn1_q[i] == lu_vaddr_i[31:22]
                   && (is_4m_q[i] || vpn0_q[i] == lu_vaddr_i[21:12]);
      if (hit_vec[i]) begin
        lu_content_o = content_q[i];
        lu_is_4m_o   = is_4m_q[i];
      end
    end
  end

  assign lu_hit_o = |hit_vec;

  // ------------------------------
  // flush select
  // ------------------------------
  always_comb begin : flush_sel
    logic va_match;
    logic asid_match;
    for (int i = 0; i < ENTRIES; i++) begin
      va_match   = vpn1_q[i] == flush_vaddr_i[31:22]
                   && (is_4m_q[i] || vpn0_q[i] == flush_vaddr_i[21:12]);
      asid_match = asid_q[i] == flush_asid_i;
      if (flush_asid_i == '0 && flush_vaddr_i == '0) begin
        flush_vec[i] = 1'b1;
      end else if (flush_asid_i == '0) begin
        // address only, globals go too
        flush_vec[i] = va_match;
      end else if (flush_vaddr_i == '0) begin
        flush_vec[i] = !glob_q[i] && asid_match;
      end else begin
        flush_vec[i] = !glob_q[i] && asid_match && va_match;
      end
    end
  end

  // ------------------------------
  // replacement
  // ------------------------------
  // first free slot wins, round-robin victim when full
  always_comb begin : victim
    logic found;
    found    = 1'b0;
    repl_idx = rr_q;
    for (int i = 0; i < ENTRIES; i++) begin
      if (!found && !valid_q[i]) begin
        repl_idx = IDX_W'(i);
        found    = 1'b1;
      end
    end
  end

  assign all_valid = &valid_q;
  assign rr_next   = (rr_q == IDX_W'(ENTRIES - 1)) ? '0 : rr_q + 1'b1;

  // refill lands after the flush of the same cycle
  always_comb begin : valid_next
    valid_d = valid_q;
    if (flush_i) begin
      valid_d = valid_d & ~flush_vec;
    end
    if (update_i) begin
      valid_d[repl_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else begin
      valid_q <= valid_d;
      // pointer only moves when a valid entry is evicted
      if (update_i && all_valid) begin
        rr_q <= rr_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i) begin
      vpn1_q[repl_idx]    <= update_vaddr_i[31:22];
      vpn0_q[repl_idx]    <= update_vaddr_i[21:12];
      asid_q[repl_idx]    <= update_asid_i;
      is_4m_q[repl_idx]   <= update_is_4m_i;
      glob_q[repl_idx]    <= update_pte_i.g;
      content_q[repl_idx] <= update_pte_i;
    end
  end

  // duplicate tags would mean the refill source broke the miss protocol
  a_single_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lu_access_i |-> $onehot0(hit_vec));

endmodule

//--- run.sh
#!/bin/sh
# build and run the sv32 mmu testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
  -f compile.f --top-module mmu_tb -o mmu_tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/mmu_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- test/mmu_ref_model.svh
// ------------------------------
// shadow copies of itlb and dtlb
// ------------------------------
`ifndef MMU_REF_MODEL_SVH
`define MMU_REF_MODEL_SVH

// first index: 0 itlb, 1 dtlb
logic          m_v    [2][4];
logic [31:0]   m_va   [2][4];
logic [3:0]    m_asid [2][4];
mmu_pkg::pte_t m_pte  [2][4];
logic          m_4m   [2][4];
int            m_rr   [2];
int            m_n    [2];

function automatic logic covers_va(int t, int i, logic [31:0] va);
  return m_va[t][i][31:22] == va[31:22] && (m_4m[t][i] || m_va[t][i][21:12] == va[21:12]);
endfunction

// hit index, -1 on a miss
function automatic int lookup_entry(int t, logic [3:0] asid, logic [31:0] va);
  for (int i = 0; i < m_n[t]; i++) begin
    if (m_v[t][i] && (m_asid[t][i] == asid || m_pte[t][i].g) && covers_va(t, i, va)) begin
      return i;
    end
  end
  return -1;
endfunction

// page present under any asid
function automatic logic page_cached(int t, logic [31:0] va);
  for (int i = 0; i < m_n[t]; i++) begin
    if (m_v[t][i] && covers_va(t, i, va)) begin
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

function automatic void place_refill(int t, logic [31:0] va, logic [3:0] asid,
                                     mmu_pkg::pte_t pte, logic is_4m);
  int idx;
  idx = -1;
  for (int i = 0; i < m_n[t]; i++) begin
    if (idx < 0 && !m_v[t][i]) begin
      idx = i;
    end
  end
  // full, so the round-robin victim goes
  if (idx < 0) begin
    idx = m_rr[t];
    m_rr[t] = (m_rr[t] + 1) % m_n[t];
  end
  m_v[t][idx]    = 1'b1;
  m_va[t][idx]   = va;
  m_asid[t][idx] = asid;
  m_pte[t][idx]  = pte;
  m_4m[t][idx]   = is_4m;
endfunction

function automatic void apply_flush(logic [3:0] asid, logic [31:0] va);
  logic kill;
  for (int t = 0; t < 2; t++) begin
    for (int i = 0; i < m_n[t]; i++) begin
      if (asid == 0 && va == 0) begin
        kill = 1'b1;
      end else if (asid == 0) begin
        kill = covers_va(t, i, va);
      end else if (va == 0) begin
        kill = !m_pte[t][i].g && m_asid[t][i] == asid;
      end else begin
        kill = !m_pte[t][i].g && m_asid[t][i] == asid && covers_va(t, i, va);
      end
      if (kill) begin
        m_v[t][i] = 1'b0;
      end
    end
  end
endfunction

`endif

//--- test/mmu_tb.sv
// ------------------------------
// testbench for the sv32 mmu
// random stimulus checked against a shadow tlb model
// ------------------------------
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_tb;

  // upper bound on clock cycles of all tests together
  localparam int TEST_CYCLES = 600;

  logic                   clk_i, rst_ni;
  logic                   enable_translation_i, en_ld_st_translation_i, sum_i;
  mmu_pkg::priv_lvl_e     priv_lvl_i, ld_st_priv_lvl_i;
  logic [`MMU_ASID_W-1:0] asid_i, flush_asid_i, refill_asid_i;
  logic                   flush_tlb_i, refill_i, refill_itlb_i, refill_is_4m_i;
  logic [`MMU_VLEN-1:0]   flush_vaddr_i, refill_vaddr_i, fetch_vaddr_i, lsu_vaddr_i;
  mmu_pkg::pte_t          refill_pte_i;
  logic                   fetch_req_i, fetch_valid_o, itlb_miss_o;
  logic [`MMU_PLEN-1:0]   fetch_paddr_o, lsu_paddr_o;
  mmu_pkg::exception_t    fetch_exception_o, lsu_exception_o;
  logic                   lsu_req_i, lsu_is_store_i, lsu_dtlb_hit_o, lsu_valid_o, dtlb_miss_o;
  logic [`MMU_PPNW-1:0]   lsu_dtlb_ppn_o;

  int n_checks, n_errors, n_tests, err_mark;

  // load/store result expected in the next cycle
  logic                 pend;
  logic                 pend_valid;
  logic [`MMU_PLEN-1:0] pend_paddr;
  mmu_pkg::exception_t  pend_exc;

  `include "mmu_ref_model.svh"

  mmu_sv32 dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    #(TEST_CYCLES * 100 + 5000);
    $display("watchdog expired, the simulation did not finish in time");
    $display("Verification failed");
    $finish;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_bit(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_paddr(input string what, input logic [`MMU_PLEN-1:0] got,
                             input logic [`MMU_PLEN-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ppn(input string what, input logic [`MMU_PPNW-1:0] got,
                           input logic [`MMU_PPNW-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_exc(input string what, input mmu_pkg::exception_t got,
                           input mmu_pkg::exception_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  // pool pages have distinct vpn1, every third one is a megapage
  function automatic logic [31:0] page_va(int k);
    logic [9:0] vpn0;
    vpn0 = (k % 3 == 0) ? 10'($urandom) : 10'(k * 37 + 5);
    return {10'(k + 1), vpn0, 12'($urandom)};
  endfunction

  function automatic logic [33:0] xlate_pa(mmu_pkg::pte_t pte, logic is_4m, logic [31:0] va);
    logic [33:0] pa;
    pa = {pte.ppn, va[11:0]};
    if (is_4m) begin
      pa[21:12] = va[21:12];
    end
    return pa;
  endfunction

  function automatic mmu_pkg::priv_lvl_e pick_priv();
    case ($urandom % 3)
      0:       return mmu_pkg::PRIV_U;
      1:       return mmu_pkg::PRIV_S;
      default: return mmu_pkg::PRIV_M;
    endcase
  endfunction

  // one refill cycle, skipped when the page is already cached
  task automatic refill(input logic itlb, input int k, input logic [3:0] asid,
                        input logic allow_g);
    mmu_pkg::pte_t p;
    logic [31:0]   va;
    int            t;
    t  = itlb ? 0 : 1;
    va = page_va(k);
    if (page_cached(t, va)) return;
    p     = '0;
    p.ppn = `MMU_PPNW'($urandom);
    p.v   = 1'b1;
    p.r   = 1'b1;
    p.x   = 1'b1;
    p.a   = 1'b1;
    p.u   = 1'($urandom % 2);
    p.w   = ($urandom % 4) != 0;
    p.d   = ($urandom % 4) != 0;
    p.g   = allow_g && ($urandom % 3 == 0);
    refill_i       = 1'b1;
    refill_itlb_i  = itlb;
    refill_vaddr_i = va;
    refill_asid_i  = asid;
    refill_pte_i   = p;
    refill_is_4m_i = (k % 3 == 0);
    place_refill(t, va, asid, p, k % 3 == 0);
    @(negedge clk_i);
    refill_i = 1'b0;
  endtask

  task automatic flush(input logic [3:0] asid, input logic [31:0] va);
    flush_tlb_i   = 1'b1;
    flush_asid_i  = asid;
    flush_vaddr_i = va;
    apply_flush(asid, va);
    @(negedge clk_i);
    flush_tlb_i = 1'b0;
  endtask

  // drives a fetch and checks the same-cycle answer, caller advances
  task automatic fetch_check(input logic [31:0] va);
    int                  idx;
    mmu_pkg::exception_t e;
    logic                acc;
    fetch_req_i   = 1'b1;
    fetch_vaddr_i = va;
    e = '0;
    #1;
    if (!enable_translation_i) begin
      check_bit("fetch_valid_o", fetch_valid_o, 1'b1);
      check_bit("itlb_miss_o", itlb_miss_o, 1'b0);
      check_paddr("fetch_paddr_o", fetch_paddr_o, {2'b00, va});
    end else begin
      idx = lookup_entry(0, asid_i, va);
      check_bit("fetch_valid_o", fetch_valid_o, idx >= 0);
      check_bit("itlb_miss_o", itlb_miss_o, idx < 0);
      if (idx >= 0) begin
        check_paddr("fetch_paddr_o", fetch_paddr_o, xlate_pa(m_pte[0][idx], m_4m[0][idx], va));
        acc = (priv_lvl_i == mmu_pkg::PRIV_U && !m_pte[0][idx].u)
           || (priv_lvl_i == mmu_pkg::PRIV_S && m_pte[0][idx].u);
        if (acc) begin
          e.cause = mmu_pkg::EXC_INSTR_PAGE_FAULT;
          e.tval  = va;
          e.valid = 1'b1;
        end
      end
    end
    check_exc("fetch_exception_o", fetch_exception_o, e);
  endtask

  // result of the previous load/store request
  task automatic lsu_result();
    if (pend) begin
      check_bit("lsu_valid_o", lsu_valid_o, pend_valid);
      if (pend_valid) begin
        check_paddr("lsu_paddr_o", lsu_paddr_o, pend_paddr);
        check_exc("lsu_exception_o", lsu_exception_o, pend_exc);
      end
    end
    pend = 1'b0;
  endtask

  // drives a load/store, checks the request cycle, caller advances
  task automatic lsu_probe(input logic [31:0] va, input logic st);
    int            idx;
    logic          acc;
    mmu_pkg::pte_t p;
    lsu_req_i      = 1'b1;
    lsu_vaddr_i    = va;
    lsu_is_store_i = st;
    pend_exc       = '0;
    pend           = 1'b1;
    #1;
    if (!en_ld_st_translation_i) begin
      check_bit("lsu_dtlb_hit_o", lsu_dtlb_hit_o, 1'b1);
      check_bit("dtlb_miss_o", dtlb_miss_o, 1'b0);
      check_ppn("lsu_dtlb_ppn_o", lsu_dtlb_ppn_o, {2'b00, va[31:12]});
      pend_valid = 1'b1;
      pend_paddr = {2'b00, va};
    end else begin
      idx = lookup_entry(1, asid_i, va);
      check_bit("lsu_dtlb_hit_o", lsu_dtlb_hit_o, idx >= 0);
      check_bit("dtlb_miss_o", dtlb_miss_o, idx < 0);
      pend_valid = idx >= 0;
      if (idx >= 0) begin
        p = m_pte[1][idx];
        check_ppn("lsu_dtlb_ppn_o", lsu_dtlb_ppn_o, p.ppn);
        pend_paddr = xlate_pa(p, m_4m[1][idx], va);
        acc = (ld_st_priv_lvl_i == mmu_pkg::PRIV_S && !sum_i && p.u)
           || (ld_st_priv_lvl_i == mmu_pkg::PRIV_U && !p.u);
        if (st && (!p.w || !p.d || acc)) begin
          pend_exc.cause = mmu_pkg::EXC_STORE_PAGE_FAULT;
        end else if (!st && acc) begin
          pend_exc.cause = mmu_pkg::EXC_LOAD_PAGE_FAULT;
        end
        if (pend_exc.cause != mmu_pkg::EXC_NONE) begin
          pend_exc.tval  = va;
          pend_exc.valid = 1'b1;
        end
      end
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("test %-12s done, %0d errors", name, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    void'($urandom(24));
    {enable_translation_i, en_ld_st_translation_i, sum_i} = '0;
    priv_lvl_i       = mmu_pkg::PRIV_S;
    ld_st_priv_lvl_i = mmu_pkg::PRIV_S;
    {asid_i, flush_asid_i, refill_asid_i} = '0;
    {flush_tlb_i, refill_i, refill_itlb_i, refill_is_4m_i} = '0;
    {flush_vaddr_i, refill_vaddr_i, fetch_vaddr_i, lsu_vaddr_i} = '0;
    refill_pte_i = '0;
    {fetch_req_i, lsu_req_i, lsu_is_store_i} = '0;
    {n_checks, n_errors, n_tests, err_mark} = '0;
    pend   = 1'b0;
    m_n[0] = `MMU_ITLB_ENTRIES;
    m_n[1] = `MMU_DTLB_ENTRIES;
    m_rr   = '{0, 0};
    m_v    = '{default: '0};
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // bare mode, both paths at once
    repeat (20) begin
      lsu_result();
      fetch_check($urandom);
      lsu_probe($urandom, 1'($urandom % 2));
      @(negedge clk_i);
    end
    lsu_result();
    lsu_req_i = 1'b0;
    finish_test("bare");

    // fetch translation
    enable_translation_i = 1'b1;
    asid_i = 4'd1;
    flush(4'd0, 32'd0);
    repeat (50) begin
      fetch_req_i = 1'b0;
      if ($urandom % 4 == 0) begin
        refill(1'b1, $urandom % 6, 4'(1 + $urandom % 2), 1'b1);
      end else begin
        priv_lvl_i = pick_priv();
        fetch_check(page_va($urandom % 6));
        @(negedge clk_i);
      end
    end
    fetch_req_i = 1'b0;
    finish_test("fetch");

    // back-to-back loads and stores
    en_ld_st_translation_i = 1'b1;
    repeat (70) begin
      lsu_result();
      if ($urandom % 4 == 0) begin
        lsu_req_i = 1'b0;
        refill(1'b0, $urandom % 6, 4'(1 + $urandom % 2), 1'b1);
      end else begin
        ld_st_priv_lvl_i = pick_priv();
        sum_i = 1'($urandom % 2);
        lsu_probe(page_va($urandom % 6), 1'($urandom % 2));
        @(negedge clk_i);
      end
    end
    lsu_result();
    lsu_req_i = 1'b0;
    finish_test("load/store");

    // six pages into four entries
    ld_st_priv_lvl_i = mmu_pkg::PRIV_S;
    sum_i = 1'b1;
    flush(4'd0, 32'd0);
    for (int k = 0; k < 6; k++) begin
      refill(1'b0, k, 4'd1, 1'b0);
    end
    for (int k = 0; k < 6; k++) begin
      lsu_result();
      lsu_probe(page_va(k), 1'b0);
      @(negedge clk_i);
    end
    lsu_result();
    lsu_req_i = 1'b0;
    finish_test("replacement");

    // all four flush forms
    for (int form = 0; form < 4; form++) begin
      flush(4'd0, 32'd0);
      for (int k = 0; k < 4; k++) begin
        refill(1'b0, k, 4'(1 + $urandom % 2), 1'b1);
      end
      flush(form[0] ? 4'(1 + $urandom % 2) : 4'd0, form[1] ? page_va($urandom % 4) : 32'd0);
      for (int a = 1; a <= 2; a++) begin
        asid_i = 4'(a);
        for (int k = 0; k < 5; k++) begin
          lsu_result();
          lsu_probe(page_va(k), 1'b0);
          @(negedge clk_i);
        end
      end
      lsu_result();
      lsu_req_i = 1'b0;
    end
    finish_test("flush");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
